//--- all.f
+incdir+tests
source/hb_pkg.sv
source/adc_capture.sv
source/switching_law.sv
source/dead_time.sv
source/gate_driver.sv
source/hbridge_top.sv
tests/tb_hbridge.sv

//--- source/adc_capture.sv
// tank current sample capture
`timescale 1ns/100ps

module adc_capture
   import hb_pkg::*;
(
   input  logic    ADA_DCO,   // converter data clock
   input  logic    i_rst,     // sync, active high
   input  adc_in_t i_adc,     // new word every cycle
   output sample_t o_sample   // conditioned current
);

   // ----------------------------------------------------------------------
   // polarity and over-range handling
   // ----------------------------------------------------------------------
   // the current sensor is wired inverted on the board, so every
   // in-range code is negated here
   // on over-range the ADC word is not trusted beyond its sign,
   // clamp to full scale of the conditioned (negated) sign
   sample_t sample_d;

   always_comb begin
      if (i_adc.over_range) begin
         if (i_adc.data == SAMPLE_NEG_FS) begin
            sample_d = SAMPLE_POS_FS;  // raw -fs -> +fs after inversion
         end else begin
            sample_d = SAMPLE_NEG_FS;  // raw +fs -> -fs
         end
      end else begin
         sample_d = -i_adc.data;  // wraps at 14 bits
      end
   end

   // one register stage on the data clock
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         o_sample <= '0;
      end else begin
         o_sample <= sample_d;
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   // an over-range word must land on a rail one cycle later
   a_or_saturates : assert property (
      @(posedge ADA_DCO) disable iff (i_rst)
      i_adc.over_range |=> (o_sample == SAMPLE_POS_FS) || (o_sample == SAMPLE_NEG_FS)
   ) else $error("adc_capture: over-range sample not saturated");

endmodule

//--- source/dead_time.sv
// gate dead-time insertion
`timescale 1ns/100ps

module dead_time
   import hb_pkg::*;
#(
   parameter int DT_STEPS [4] = '{10, 20, 40, 60}  // selectable dead times in cycles
)(
   input  logic                ADA_DCO,
   input  logic                i_rst,
   input  logic [DT_SEL_W-1:0] i_dt_sel,    // run-time dead-time choice
   input  gate_t               i_gate_cmd,  // raw pattern from the law
   output gate_t               o_gate       // turn-on edges held back
);

   // longest dead time sets the counter width
   function automatic int dt_max_of();
      int m;
      m = 0;
      for (int k = 0; k < 4; k++) begin
         if (DT_STEPS[k] > m) begin
            m = DT_STEPS[k];
         end
      end
      return m;
   endfunction

   // shortest dead time bounds every turn-on
   function automatic int dt_min_of();
      int m;
      m = DT_STEPS[0];
      for (int k = 1; k < 4; k++) begin
         if (DT_STEPS[k] < m) begin
            m = DT_STEPS[k];
         end
      end
      return m;
   endfunction

   localparam int DT_MAX = dt_max_of();
   localparam int DT_MIN = dt_min_of();
   localparam int CNT_W  = $clog2(DT_MAX + 1);

   // ----------------------------------------------------------------------
   // per-switch on-time counters
   // ----------------------------------------------------------------------
   logic [3:0]       cmd_bits;         // q4..q1 as plain bits
   logic [3:0]       q_bits;           // delayed gates
   logic [CNT_W-1:0] on_cnt [4];       // cycles the command has been high
   logic [CNT_W-1:0] dt_cnt;           // selected dead time

   assign cmd_bits = i_gate_cmd;
   assign dt_cnt   = CNT_W'(DT_STEPS[i_dt_sel]);  // mux over the four steps

   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         for (int k = 0; k < 4; k++) begin
            on_cnt[k] <= '0;
         end
         q_bits <= GATE_OFF;
      end else begin
         for (int k = 0; k < 4; k++) begin
            if (!cmd_bits[k]) begin
               on_cnt[k] <= '0;  // command low restarts the wait
            end else if (on_cnt[k] != CNT_W'(DT_MAX)) begin
               on_cnt[k] <= on_cnt[k] + 1'b1;  // saturates at the longest step
            end
            // off passes next cycle, on waits for the count
            q_bits[k] <= cmd_bits[k] && (on_cnt[k] >= dt_cnt);
         end
      end
   end

   assign o_gate = q_bits;

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   // a rising command keeps its gate low for at least the shortest dead time
   for (genvar g = 0; g < 4; g++) begin : g_chk
      a_on_delayed : assert property (
         @(posedge ADA_DCO) disable iff (i_rst)
         $rose(cmd_bits[g]) |-> (!q_bits[g]) [*DT_MIN+1]
      ) else $error("dead_time: gate %0d turned on inside the dead time", g);
   end

endmodule

//--- source/gate_driver.sv
// bridge output stage and start-up
`timescale 1ns/100ps

module gate_driver
   import hb_pkg::*;
#(
   parameter int ON_CYCLES = 1000,  // bootstrap charge time
   parameter int VG_CYCLES = 1600   // end of forced sigma = 1
)(
   input  logic  ADA_DCO,
   input  logic  i_rst,
   input  logic  i_enable,      // bridge enable level
   input  gate_t i_gate,        // dead-timed pattern
   output gate_t o_gate,        // to the gate drivers
   output logic  o_gate_ready   // start-up done
);

   localparam int CNT_W = $clog2(VG_CYCLES + 1);

   // ----------------------------------------------------------------------
   // start-up sequencer
   // ----------------------------------------------------------------------
   // low sides first so the high-side bootstrap caps charge,
   // then sigma = 1 for a while to get the tank swinging
   logic [CNT_W-1:0] startup_cnt;
   gate_t            gate_raw;
   gate_t            gate_mask;
   logic             leg_overlap;

   always_ff @(posedge ADA_DCO) begin
      if (i_rst || !i_enable) begin
         startup_cnt <= '0;  // every enable restarts the sequence
      end else if (startup_cnt != CNT_W'(VG_CYCLES)) begin
         startup_cnt <= startup_cnt + 1'b1;  // stops at the end
      end
   end

   always_comb begin
      if (startup_cnt < CNT_W'(ON_CYCLES)) begin
         gate_raw = GATE_BOOT;
      end else if (startup_cnt < CNT_W'(VG_CYCLES)) begin
         gate_raw = GATE_SIGMA1;
      end else begin
         gate_raw = i_gate;  // normal operation
      end
   end

   // shoot-through guard on either leg
   assign leg_overlap = (gate_raw.q1 && gate_raw.q3) || (gate_raw.q2 && gate_raw.q4);
   assign gate_mask   = (i_enable && !leg_overlap) ? gate_raw : GATE_OFF;

   // ----------------------------------------------------------------------
   // output register
   // ----------------------------------------------------------------------
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         o_gate       <= GATE_OFF;
         o_gate_ready <= 1'b0;
      end else begin
         o_gate       <= gate_mask;
         o_gate_ready <= i_enable && (startup_cnt == CNT_W'(VG_CYCLES));  // aligned with o_gate
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   // the dead-timed word must already keep each leg clean
   a_no_overlap : assert property (
      @(posedge ADA_DCO) disable iff (i_rst)
      !(i_gate.q1 && i_gate.q3) && !(i_gate.q2 && i_gate.q4)
   ) else $error("gate_driver: same-leg overlap on dead-timed input");

   // a new enable starts over with the bootstrap charge
   a_restart_boot : assert property (
      @(posedge ADA_DCO) disable iff (i_rst)
      !i_enable ##1 i_enable |=> (o_gate == GATE_BOOT) && !o_gate_ready
   ) else $error("gate_driver: enable did not restart the start-up sequence");

endmodule

//--- source/hb_pkg.sv
// half-bridge gate path types
package hb_pkg;

   // ----------------------------------------------------------------------
   // converter word
   // ----------------------------------------------------------------------
   localparam int ADC_W = 14;  // ADA data bus width

   typedef logic signed [ADC_W-1:0] sample_t;  // tank current, two's complement

   // one conversion as it leaves the ADC pins
   typedef struct packed {
      sample_t data;        // raw word, board polarity
      logic    over_range;  // ADA_OR
   } adc_in_t;

   localparam sample_t SAMPLE_POS_FS = 14'h1FFF;  // +8191
   localparam sample_t SAMPLE_NEG_FS = 14'h2000;  // -8192

   // ----------------------------------------------------------------------
   // bridge gates
   // ----------------------------------------------------------------------
   // leg 1 is q1 high / q3 low
   // leg 2 is q2 high / q4 low
   typedef struct packed {
      logic q4;
      logic q3;
      logic q2;
      logic q1;  // lsb
   } gate_t;

   localparam gate_t GATE_OFF    = '{q4: 1'b0, q3: 1'b0, q2: 1'b0, q1: 1'b0};
   localparam gate_t GATE_SIGMA1 = '{q4: 1'b1, q3: 1'b0, q2: 1'b0, q1: 1'b1};  // diagonal a
   localparam gate_t GATE_SIGMA0 = '{q4: 1'b0, q3: 1'b1, q2: 1'b1, q1: 1'b0};  // diagonal b
   localparam gate_t GATE_BOOT   = '{q4: 1'b1, q3: 1'b1, q2: 1'b0, q1: 1'b0};  // both low sides

   // dead-time selector
   localparam int DT_SEL_W = 2;  // four dead times

endpackage

//--- source/hbridge_top.sv
// resonant bridge gate path top
`timescale 1ns/100ps

module hbridge_top
   import hb_pkg::*;
#(
   parameter int HYST         = 200,                 // switching band, adc codes
   parameter int DT_STEPS [4] = '{10, 20, 40, 60},   // dead times, cycles
   parameter int ON_CYCLES    = 1000,                // bootstrap charge, cycles
   parameter int VG_CYCLES    = 1600                 // end of forced sigma = 1
)(
   input  logic                ADA_DCO,       // adc data clock, sole clock
   input  logic                i_rst,
   input  adc_in_t             i_adc,         // tank current conversion
   input  logic                i_enable,
   input  logic [DT_SEL_W-1:0] i_dt_sel,
   output gate_t               o_gate,        // q4..q1
   output sample_t             o_sample,      // conditioned current
   output logic                o_gate_ready
);

   // ----------------------------------------------------------------------
   // chain adc -> law -> dead time -> output stage
   // ----------------------------------------------------------------------
   gate_t gate_cmd;   // sigma pattern
   gate_t gate_dt;    // after dead time

   adc_capture u_adc_capture (
      .ADA_DCO  (ADA_DCO),
      .i_rst    (i_rst),
      .i_adc    (i_adc),
      .o_sample (o_sample)  // also feeds the law
   );

   switching_law #(
      .HYST (HYST)
   ) u_switching_law (
      .ADA_DCO    (ADA_DCO),
      .i_rst      (i_rst),
      .i_sample   (o_sample),
      .o_gate_cmd (gate_cmd)
   );

   dead_time #(
      .DT_STEPS (DT_STEPS)
   ) u_dead_time (
      .ADA_DCO    (ADA_DCO),
      .i_rst      (i_rst),
      .i_dt_sel   (i_dt_sel),
      .i_gate_cmd (gate_cmd),
      .o_gate     (gate_dt)
   );

   gate_driver #(
      .ON_CYCLES (ON_CYCLES),
      .VG_CYCLES (VG_CYCLES)
   ) u_gate_driver (
      .ADA_DCO      (ADA_DCO),
      .i_rst        (i_rst),
      .i_enable     (i_enable),
      .i_gate       (gate_dt),
      .o_gate       (o_gate),
      .o_gate_ready (o_gate_ready)
   );

endmodule

//--- source/switching_law.sv
// hysteresis switching law
`timescale 1ns/100ps

module switching_law
   import hb_pkg::*;
#(
   parameter int HYST = 200  // half band width in adc codes
)(
   input  logic    ADA_DCO,
   input  logic    i_rst,
   input  sample_t i_sample,   // conditioned tank current
   output gate_t   o_gate_cmd  // diagonal pattern from sigma
);

   // ----------------------------------------------------------------------
   // hybrid state
   // ----------------------------------------------------------------------
   // sigma = 1 drives q1/q4 and pushes the current negative,
   // sigma = 0 drives q2/q3 and pushes it positive
   // the band around zero keeps the bridge from chattering on noise
   logic sigma;
   logic above_band;
   logic below_band;

   assign above_band = (i_sample > HYST);   // clear positive current
   assign below_band = (i_sample < -HYST);  // clear negative current

   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         sigma <= 1'b0;  // start on diagonal b
      end else if (above_band) begin
         sigma <= 1'b1;
      end else if (below_band) begin
         sigma <= 1'b0;
      end
      // inside the band sigma holds
   end

   // state to gate pattern
   // plain decode, latency stays at the sigma register
   always_comb begin
      if (sigma) begin
         o_gate_cmd = GATE_SIGMA1;
      end else begin
         o_gate_cmd = GATE_SIGMA0;
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   // a jump of sigma must come from a sample outside the band
   a_sigma_band : assert property (
      @(posedge ADA_DCO) disable iff (i_rst)
      $changed(sigma) |-> (($past(i_sample) > HYST) || ($past(i_sample) < -HYST))
   ) else $error("switching_law: sigma moved inside the hysteresis band");

endmodule

//--- tests/hbridge_patterns.txt
// id enable dt_sel adc_data over_range hold exp_gate exp_sample exp_ready
// all columns hex, hold is in ADA_DCO cycles, gate is q4..q1
01 0 0 0000 0 05 0 0000 0
02 0 0 0050 0 01 0 3FB0 0
03 0 0 1FFF 1 01 0 2000 0
04 0 0 2000 1 01 0 1FFF 0
05 0 0 3C18 0 01 0 03E8 0
06 0 0 2000 0 01 0 2000 0
// start-up, ON_CYCLES 20 and VG_CYCLES 40
07 1 0 03E8 0 14 C 3C18 0
08 1 0 03E8 0 01 9 3C18 0
09 1 0 03E8 0 13 9 3C18 0
0A 1 0 03E8 0 01 6 3C18 1
// hysteresis, HYST 200
0B 1 3 3C18 0 48 9 03E8 1
0C 1 3 0050 0 48 9 3FB0 1
0D 1 3 03E8 0 48 6 3C18 1
0E 1 3 3F38 0 48 6 00C8 1
// dead time 10 20 40 60, checked at 4+DT-1 and 4+DT
0F 1 0 3C18 0 0D 0 03E8 1
10 1 0 3C18 0 01 9 03E8 1
11 1 1 03E8 0 17 0 3C18 1
12 1 1 03E8 0 01 6 3C18 1
13 1 2 3C18 0 2B 0 03E8 1
14 1 2 3C18 0 01 9 03E8 1
15 1 3 03E8 0 3F 0 3C18 1
16 1 3 03E8 0 01 6 3C18 1
// disable and restart
17 0 3 03E8 0 01 0 3C18 0
18 1 3 03E8 0 14 C 3C18 0
19 1 3 03E8 0 14 9 3C18 0
1A 1 3 03E8 0 01 6 3C18 1

//--- tests/tb_checks.svh
// result compare tasks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------------------------------------
// one task per result type, all count into err_count
// ----------------------------------------------------------------------

// full gate word, q4..q1
task automatic check_gate(input string name, input gate_t got, input gate_t exp);
   if (got !== exp) begin
      $display("ERR %s: got 0x%h expected 0x%h (test 0x%02h)", name, got, exp, cur_test);
      err_count++;
   end
endtask

// conditioned current sample
task automatic check_sample(input string name, input sample_t got, input sample_t exp);
   if (got !== exp) begin
      $display("ERR %s: got 0x%h expected 0x%h (test 0x%02h)", name, got, exp, cur_test);
      err_count++;
   end
endtask

// single status level
task automatic check_ready(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("ERR %s: got 0x%h expected 0x%h (test 0x%02h)", name, got, exp, cur_test);
      err_count++;
   end
endtask

`endif

//--- tests/tb_hbridge.sv
// gate path testbench
`timescale 1ns/100ps

module tb_hbridge
   import hb_pkg::*;
();

   localparam int HYST         = 200;
   localparam int DT_STEPS [4] = '{10, 20, 40, 60};
   localparam int ON_CYCLES    = 20;   // short start-up for simulation
   localparam int VG_CYCLES    = 40;
   localparam int CLK_HALF     = 5;    // 10 ns period
   localparam int RST_CYCLES   = 2;
   localparam int COLS         = 9;    // words per pattern row
   localparam int MAX_ROWS     = 64;

   logic                ADA_DCO;
   logic                i_rst;
   adc_in_t             i_adc;
   logic                i_enable;
   logic [DT_SEL_W-1:0] i_dt_sel;
   gate_t               o_gate;
   sample_t             o_sample;
   logic                o_gate_ready;

   logic [31:0] pat_mem [0:COLS*MAX_ROWS-1];  // unread words stay x or zero
   integer      seed;
   int          err_count;
   int          pass_count;
   int          fail_count;
   int          cur_test;
   int          n_rows;
   int          limit_cycles;  // 0 until the patterns are loaded

   `include "tb_checks.svh"

   hbridge_top #(
      .HYST      (HYST),
      .DT_STEPS  (DT_STEPS),
      .ON_CYCLES (ON_CYCLES),
      .VG_CYCLES (VG_CYCLES)
   ) u_dut (
      .ADA_DCO      (ADA_DCO),
      .i_rst        (i_rst),
      .i_adc        (i_adc),
      .i_enable     (i_enable),
      .i_dt_sel     (i_dt_sel),
      .o_gate       (o_gate),
      .o_sample     (o_sample),
      .o_gate_ready (o_gate_ready)
   );

   initial begin
      ADA_DCO = 1'b0;
      forever #CLK_HALF ADA_DCO = ~ADA_DCO;
   end

   // ----------------------------------------------------------------------
   // stimulus helpers
   // ----------------------------------------------------------------------
   // set inputs now (1 ns past an edge), then step to 1 ns past the next edge
   task automatic drive_cycle(input logic en, input logic [DT_SEL_W-1:0] dt,
                              input sample_t data, input logic ovr);
      i_enable         = en;
      i_dt_sel         = dt;
      i_adc.data       = data;
      i_adc.over_range = ovr;
      @(posedge ADA_DCO);
      #1;
   endtask

   // first and last cycle carry the row data, the middle gets in-band noise
   task automatic run_row(input int row);
      int                  base;
      int                  hold;
      int                  errs_before;
      int                  noise;
      logic                en;
      logic [DT_SEL_W-1:0] dt;
      sample_t             data;
      logic                ovr;
      gate_t               exp_gate;
      sample_t             exp_sample;
      logic                exp_ready;
      base        = row * COLS;
      cur_test    = pat_mem[base];
      en          = pat_mem[base+1][0];
      dt          = pat_mem[base+2][DT_SEL_W-1:0];
      data        = sample_t'(pat_mem[base+3][ADC_W-1:0]);
      ovr         = pat_mem[base+4][0];
      hold        = pat_mem[base+5];
      exp_gate    = gate_t'(pat_mem[base+6][3:0]);
      exp_sample  = sample_t'(pat_mem[base+7][ADC_W-1:0]);
      exp_ready   = pat_mem[base+8][0];
      errs_before = err_count;
      for (int c = 0; c < hold; c++) begin
         if (c == 0 || c == hold - 1) begin
            drive_cycle(en, dt, data, ovr);
         end else begin
            noise = $random(seed) % (HYST + 1);  // |noise| <= HYST, sigma holds
            drive_cycle(en, dt, sample_t'(noise), 1'b0);
         end
      end
      check_gate("o_gate", o_gate, exp_gate);
      check_sample("o_sample", o_sample, exp_sample);
      check_ready("o_gate_ready", o_gate_ready, exp_ready);
      if (err_count == errs_before) begin
         pass_count++;
         $display("test 0x%02h ok", cur_test);
      end else begin
         fail_count++;
         $display("test 0x%02h failed, %0d mismatches", cur_test, err_count - errs_before);
      end
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      int hold_sum;
      i_rst            = 1'b1;
      i_enable         = 1'b0;
      i_dt_sel         = '0;
      i_adc.data       = '0;
      i_adc.over_range = 1'b0;
      seed             = 32'h191e_58c2;
      err_count        = 0;
      pass_count       = 0;
      fail_count       = 0;
      cur_test         = 0;
      limit_cycles     = 0;
      hold_sum         = 0;
      $readmemh("tests/hbridge_patterns.txt", pat_mem);
      n_rows = 0;
      // rows end at the first unread or zero id
      while (n_rows < MAX_ROWS && !$isunknown(pat_mem[n_rows*COLS])
             && pat_mem[n_rows*COLS] != 0) begin
         hold_sum += pat_mem[n_rows*COLS + 5];
         n_rows++;
      end
      limit_cycles = RST_CYCLES + hold_sum + 100;  // arms the watchdog
      repeat (RST_CYCLES) @(posedge ADA_DCO);
      #1;
      i_rst = 1'b0;
      for (int r = 0; r < n_rows; r++) begin
         run_row(r);
      end
      if (n_rows == 0) begin
         $display("no pattern rows could be read");
      end
      $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
               n_rows, pass_count, fail_count, err_count);
      if (fail_count == 0 && n_rows > 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // watchdog, limit follows the total hold time in the pattern file
   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge ADA_DCO);
      $display("timeout: tests did not finish within %0d cycles", limit_cycles);
      $display("Result: FAILED");
      $finish;
   end

endmodule
